// ==== dv/rvFrontEndTb.sv ====
`timescale 1ns/1ps

module rvFrontEndTb;
    import rvPkg::*;

    localparam int ROWS = 30;
    localparam int CYCLE_LIMIT = 3 * ROWS + 50;
    // stall while the first taken branch waits in ID
    localparam int STALL_AT = 8;
    localparam int STALL_LEN = 4;

    logic clk;
    logic rstN;
    logic imemWe;
    imAddrT imemAddr;
    instrT imemData;
    logic stall;
    wbT wb;
    idExT idEx;
    wordT fetchPc;

    // program table
    instrT instrTab [ROWS];
    wordT immTab [ROWS];
    ctrlT ctrlTab [ROWS];
    logic takenTab [ROWS];

    // register model and expected idEx stream
    wordT regs [REG_COUNT];
    idExT expQ [$];
    int rowQ [$];
    int seed;
    int errors;
    int checks;
    int cycles;
    wordT fwdVal;

    rvFrontEnd dut0 (
        .clk(clk),
        .rstN(rstN),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .stall(stall),
        .wb(wb),
        .idEx(idEx),
        .fetchPc(fetchPc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I encoders built from the base formats
    function automatic instrT encR(logic [6:0] f7, regAddrT rs2, regAddrT rs1,
                                   funct3T f3, regAddrT rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic instrT encI(wordT imm, regAddrT rs1, funct3T f3, regAddrT rd,
                                   logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic instrT encS(wordT imm, regAddrT rs2, regAddrT rs1, funct3T f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic instrT encB(wordT imm, regAddrT rs2, regAddrT rs1, funct3T f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic instrT encU(logic [19:0] imm, regAddrT rd, logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instrT encJ(wordT imm, regAddrT rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // flags are jump jumpReg branch memRead memWrite memToReg regWrite
    function automatic ctrlT mkCtrl(logic [6:0] flags, aluSrcT s1, aluSrcT s2,
                                    aluOpT op, immSelT sel);
        return {flags, s1, s2, op, sel};
    endfunction

    task automatic setRow(int i, instrT ins, wordT imm, ctrlT c, logic taken);
        instrTab[i] = ins;
        immTab[i] = imm;
        ctrlTab[i] = c;
        takenTab[i] = taken;
    endtask

    // taken branch, wrong-path slot, then the same condition not taken
    task automatic branchTrio(int base, funct3T f3, regAddrT tA, regAddrT tB,
                              regAddrT nA, regAddrT nB);
        ctrlT cBr;
        cBr = mkCtrl(7'b0010000, SRC1_RS1, SRC2_RS2, ALU_BRANCH, IMM_B);
        setRow(base, encB(32'd8, tB, tA, f3), 32'd8, cBr, 1'b1);
        setRow(base + 1, encI(32'd1, 5'd0, 3'b000, 5'd20, OP_IMM), 32'd1,
               mkCtrl(7'b0000001, SRC1_RS1, SRC2_IMM, ALU_IMM, IMM_I), 1'b0);
        setRow(base + 2, encB(32'd8, nB, nA, f3), 32'd8, cBr, 1'b0);
    endtask

    task automatic buildTable();
        ctrlT cImm;
        ctrlT cReg;
        cImm = mkCtrl(7'b0000001, SRC1_RS1, SRC2_IMM, ALU_IMM, IMM_I);
        cReg = mkCtrl(7'b0000001, SRC1_RS1, SRC2_RS2, ALU_REG, IMM_NONE);
        setRow(0, encI(32'hFFFF_FFFB, 5'd6, 3'b000, 5'd7, OP_IMM), 32'hFFFF_FFFB, cImm, 1'b0);
        setRow(1, encS(32'd12, 5'd9, 5'd8, 3'b010), 32'd12,
               mkCtrl(7'b0000100, SRC1_RS1, SRC2_IMM, ALU_ADD, IMM_S), 1'b0);
        setRow(2, encU(20'h12345, 5'd10, OP_LUI), 32'h1234_5000,
               mkCtrl(7'b0000001, SRC1_ZERO, SRC2_IMM, ALU_ADD, IMM_U), 1'b0);
        setRow(3, encU(20'hABCDE, 5'd11, OP_AUIPC), 32'hABCD_E000,
               mkCtrl(7'b0000001, SRC1_PC, SRC2_IMM, ALU_ADD, IMM_U), 1'b0);
        setRow(4, encR(7'h00, 5'd14, 5'd13, 3'b000, 5'd12), 32'd0, cReg, 1'b0);
        setRow(5, encI(32'hFFFF_FFF0, 5'd16, 3'b010, 5'd15, OP_LOAD), 32'hFFFF_FFF0,
               mkCtrl(7'b0001011, SRC1_RS1, SRC2_IMM, ALU_ADD, IMM_I), 1'b0);
        setRow(6, encR(7'h20, 5'd19, 5'd18, 3'b000, 5'd17), 32'd0, cReg, 1'b0);
        // x1 positive, x2 equal to x1, x3 negative
        branchTrio(7, F3_BEQ, 5'd1, 5'd2, 5'd1, 5'd3);
        branchTrio(10, F3_BNE, 5'd1, 5'd3, 5'd1, 5'd2);
        branchTrio(13, F3_BLT, 5'd3, 5'd1, 5'd1, 5'd3);
        branchTrio(16, F3_BGE, 5'd1, 5'd3, 5'd3, 5'd1);
        branchTrio(19, F3_BLTU, 5'd1, 5'd3, 5'd3, 5'd1);
        branchTrio(22, F3_BGEU, 5'd3, 5'd1, 5'd1, 5'd3);
        setRow(25, encJ(32'd8, 5'd5), 32'd8,
               mkCtrl(7'b1000001, SRC1_PC, SRC2_FOUR, ALU_ADD, IMM_J), 1'b1);
        setRow(26, encI(32'd1, 5'd0, 3'b000, 5'd20, OP_IMM), 32'd1, cImm, 1'b0);
        // odd offset so bit 0 must be dropped
        setRow(27, encI(32'h75, 5'd0, 3'b000, 5'd0, OP_JALR), 32'h75,
               mkCtrl(7'b0100001, SRC1_PC, SRC2_FOUR, ALU_ADD, IMM_I), 1'b1);
        setRow(28, encI(32'd1, 5'd0, 3'b000, 5'd20, OP_IMM), 32'd1, cImm, 1'b0);
        setRow(29, encI(32'h7FF, 5'd22, 3'b110, 5'd21, OP_IMM), 32'h7FF, cImm, 1'b0);
    endtask

    // walk the table by the redirect rule
    task automatic buildExpected();
        wordT pc;
        int idx;
        instrT ins;
        idExT e;
        pc = '0;
        while (pc / 4 < ROWS) begin
            idx = int'(pc / 4);
            ins = instrTab[idx];
            e = '0;
            e.valid = 1'b1;
            e.pc = pc;
            e.rs1 = ins[19:15];
            e.rs2 = ins[24:20];
            e.rd = ins[11:7];
            e.funct3 = ins[14:12];
            e.funct7 = ins[31:25];
            e.rs1Data = regs[e.rs1];
            e.rs2Data = regs[e.rs2];
            e.imm = immTab[idx];
            e.ctrl = ctrlTab[idx];
            expQ.push_back(e);
            rowQ.push_back(idx);
            if (takenTab[idx]) begin
                expQ.push_back('0);
                rowQ.push_back(-1);
                if (ins[6:0] == OP_JALR) begin
                    pc = (regs[e.rs1] + immTab[idx]) & ~32'd1;
                end else begin
                    pc = pc + immTab[idx];
                end
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic checkWord(string name, wordT exp, wordT act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkCtrl(string name, ctrlT exp, ctrlT act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected ctrl %h, actual ctrl %h", name, exp, act);
        end
    endtask

    task automatic checkBundle(string name, idExT exp, idExT act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // empty slot only needs valid low and no control
    task automatic checkBubble(string name);
        checkWord({name, " valid"}, 32'd0, {31'b0, idEx.valid});
        checkCtrl({name, " ctrl"}, '0, idEx.ctrl);
    endtask

    // run limit
    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        int k;
        logic stallAtEdge;
        wordT prevPc;
        idExT e;
        int row;
        seed = 6;
        errors = 0;
        checks = 0;
        rstN <= 1'b0;
        stall <= 1'b1;
        imemWe <= 1'b0;
        imemAddr <= '0;
        imemData <= '0;
        wb <= '0;
        buildTable();
        regs[0] = '0;
        for (int i = 1; i < REG_COUNT; i++) begin
            regs[i] = $random(seed);
        end
        regs[1] = (regs[1] & 32'h3FFF_FFFF) | 32'd1;
        regs[2] = regs[1];
        regs[3] = regs[3] | 32'h8000_0000;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        // load program with the pipe stalled
        for (int i = 0; i < ROWS; i++) begin
            @(posedge clk);
            imemWe <= 1'b1;
            imemAddr <= imAddrT'(i);
            imemData <= instrTab[i];
            @(negedge clk);
            checkWord("reset fetchPc", 32'd0, fetchPc);
            checkBubble("reset idEx");
        end
        @(posedge clk);
        imemWe <= 1'b0;
        for (int i = 1; i < REG_COUNT; i++) begin
            @(posedge clk);
            wb <= '{regWrite: 1'b1, rd: regAddrT'(i), data: regs[i]};
        end
        @(posedge clk);
        wb <= '0;
        // x6 is rewritten while row 0 sits in ID
        fwdVal = regs[6] ^ ($random(seed) | 32'd1);
        regs[6] = fwdVal;
        buildExpected();
        prevPc = fetchPc;
        k = 0;
        while (expQ.size() > 0) begin
            @(posedge clk);
            stallAtEdge = stall;
            if (k == 0) begin
                stall <= 1'b0;
            end else if (k == 1) begin
                wb <= '{regWrite: 1'b1, rd: 5'd6, data: fwdVal};
            end else if (k == 2) begin
                wb <= '0;
            end
            if (k == STALL_AT) begin
                stall <= 1'b1;
            end else if (k == STALL_AT + STALL_LEN) begin
                stall <= 1'b0;
            end
            @(negedge clk);
            if (k < 2) begin
                checkBubble("pipe fill");
            end else if (stallAtEdge) begin
                checkWord("stall fetchPc", prevPc, fetchPc);
                checkBubble("stall idEx");
            end else begin
                e = expQ.pop_front();
                row = rowQ.pop_front();
                if (!e.valid) begin
                    checkBubble("transfer bubble");
                end else begin
                    checkBundle($sformatf("row %0d", row), e, idEx);
                end
            end
            prevPc = fetchPc;
            k++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== logic/branchCompare.sv ====
`timescale 1ns/1ps

module branchCompare (
    input rvPkg::wordT rs1Data,
    input rvPkg::wordT rs2Data,
    input rvPkg::funct3T funct3,
    output logic condTrue
);
    import rvPkg::*;

    logic isEq;
    logic isLt;
    logic isLtu;

    // one compare of each kind, funct3 picks
    assign isEq = (rs1Data == rs2Data);
    assign isLt = ($signed(rs1Data) < $signed(rs2Data));
    assign isLtu = (rs1Data < rs2Data);

    always_comb begin
        case (funct3)
            F3_BEQ: condTrue = isEq;
            F3_BNE: condTrue = !isEq;
            F3_BLT: condTrue = isLt;
            F3_BGE: condTrue = !isLt;
            F3_BLTU: condTrue = isLtu;
            F3_BGEU: condTrue = !isLtu;
            // 010 and 011 are reserved
            default: condTrue = 1'b0;
        endcase
    end

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input rvPkg::instrT instr,
    output rvPkg::ctrlT ctrl
);
    import rvPkg::*;

    always_comb begin
        // all zero is a harmless no-op
        ctrl = '0;
        case (instr[6:0])
            OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc1 = SRC1_ZERO;
                ctrl.aluSrc2 = SRC2_IMM;
                ctrl.immSel = IMM_U;
            end
            OP_AUIPC: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc1 = SRC1_PC;
                ctrl.aluSrc2 = SRC2_IMM;
                ctrl.immSel = IMM_U;
            end
            OP_JAL: begin
                // link value is pc + 4 later in EX
                ctrl.jump = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc1 = SRC1_PC;
                ctrl.aluSrc2 = SRC2_FOUR;
                ctrl.immSel = IMM_J;
            end
            OP_JALR: begin
                ctrl.jumpReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc1 = SRC1_PC;
                ctrl.aluSrc2 = SRC2_FOUR;
                ctrl.immSel = IMM_I;
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp = ALU_BRANCH;
                ctrl.immSel = IMM_B;
            end
            OP_LOAD: begin
                ctrl.memRead = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc2 = SRC2_IMM;
                ctrl.immSel = IMM_I;
            end
            OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc2 = SRC2_IMM;
                ctrl.immSel = IMM_S;
            end
            OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc2 = SRC2_IMM;
                ctrl.aluOp = ALU_IMM;
                ctrl.immSel = IMM_I;
            end
            OP_REG: begin
                // both operands from the register file
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc1 = SRC1_RS1;
                ctrl.aluSrc2 = SRC2_RS2;
                ctrl.aluOp = ALU_REG;
                ctrl.immSel = IMM_NONE;
            end
            default: begin
                ctrl.aluOp = ALU_ADD;
            end
        endcase
    end

endmodule

// ==== logic/idExRegister.sv ====
`timescale 1ns/1ps

module idExRegister (
    input logic clk,
    input logic rstN,
    input logic stall,
    input rvPkg::ifIdT ifId,
    input rvPkg::ctrlT ctrl,
    input rvPkg::immSetT imms,
    input rvPkg::wordT rs1Data,
    input rvPkg::wordT rs2Data,
    output rvPkg::idExT idEx
);
    import rvPkg::*;

    wordT selImm;
    idExT nextBundle;

    // one immediate forwarded to EX
    always_comb begin
        case (ctrl.immSel)
            IMM_I: selImm = imms.immI;
            IMM_S: selImm = imms.immS;
            IMM_B: selImm = imms.immB;
            IMM_U: selImm = imms.immU;
            IMM_J: selImm = imms.immJ;
            default: selImm = '0;
        endcase
    end

    // field split of the ID word
    always_comb begin
        nextBundle.valid = 1'b1;
        nextBundle.pc = ifId.pc;
        nextBundle.rs1Data = rs1Data;
        nextBundle.rs2Data = rs2Data;
        nextBundle.imm = selImm;
        nextBundle.rs1 = ifId.instr[19:15];
        nextBundle.rs2 = ifId.instr[24:20];
        nextBundle.rd = ifId.instr[11:7];
        nextBundle.funct3 = ifId.instr[14:12];
        nextBundle.funct7 = ifId.instr[31:25];
        nextBundle.ctrl = ctrl;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (stall || !ifId.valid) begin
            // bubble with no side effects downstream
            idEx <= '0;
        end else begin
            idEx <= nextBundle;
        end
    end

endmodule

// ==== logic/ifIdRegister.sv ====
`timescale 1ns/1ps

module ifIdRegister (
    input logic clk,
    input logic rstN,
    input logic stall,
    input logic flush,
    input rvPkg::wordT pc,
    input rvPkg::instrT instr,
    output rvPkg::ifIdT ifId
);
    import rvPkg::*;

    // empty slot carries a NOP word
    localparam ifIdT BUBBLE = '{valid: 1'b0, pc: '0, instr: NOP_INSTR};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifId <= BUBBLE;
        end else if (flush) begin
            // kill the wrong-path fetch
            ifId <= BUBBLE;
        end else if (!stall) begin
            ifId <= '{valid: 1'b1, pc: pc, instr: instr};
        end
        // stall keeps the held instruction
    end

    // redirect is suppressed by the PC unit while stalled
    aNoFlushInStall: assert property (
        @(posedge clk) disable iff (!rstN) stall |-> !flush
    ) else $error("flush raised during stall");

endmodule

// ==== logic/immExtend.sv ====
`timescale 1ns/1ps

module immExtend (
    input rvPkg::instrT instr,
    output rvPkg::immSetT imms
);
    import rvPkg::*;

    // sign bit shared by every format
    logic sign;

    assign sign = instr[31];

    // I type, loads and jalr and op-imm
    assign imms.immI = {{20{sign}}, instr[31:20]};

    // S type, split around rd field
    assign imms.immS = {{20{sign}}, instr[31:25], instr[11:7]};

    // B type, halfword offset
    assign imms.immB = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};

    // U type, upper 20 bits
    assign imms.immU = {instr[31:12], 12'b0};

    // J type, scrambled halfword offset
    assign imms.immJ = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

// ==== logic/insMemory.sv ====
`timescale 1ns/1ps

module insMemory (
    input logic clk,
    input logic imemWe,
    input rvPkg::imAddrT imemAddr,
    input rvPkg::instrT imemData,
    input rvPkg::wordT readAddr,
    output rvPkg::instrT instr
);
    import rvPkg::*;

    // one instruction per word
    instrT mem [IM_DEPTH];

    // load port writes at the edge
    always_ff @(posedge clk) begin
        if (imemWe) begin
            mem[imemAddr] <= imemData;
        end
    end

    // byte address to word index, bits 1:0 dropped
    assign instr = mem[readAddr[IM_ADDR_W+1:2]];

    // fetch address comes from the PC unit and must stay aligned
    aFetchAligned: assert property (
        @(posedge clk) !$isunknown(readAddr) |-> readAddr[1:0] == 2'b00
    ) else $error("instruction fetch at misaligned address %h", readAddr);

endmodule

// ==== logic/nextPcUnit.sv ====
`timescale 1ns/1ps

module nextPcUnit (
    input logic clk,
    input logic rstN,
    input logic stall,
    input rvPkg::ifIdT ifId,
    input rvPkg::ctrlT ctrl,
    input rvPkg::immSetT imms,
    input rvPkg::wordT rs1Data,
    input logic condTrue,
    output rvPkg::wordT fetchPc,
    output logic flush
);
    import rvPkg::*;

    logic redirect;
    wordT pcPlus4;
    wordT jumpBase;
    wordT jumpOffset;
    wordT jumpSum;
    wordT target;

    // transfer resolved in ID, only for a live slot
    assign redirect = ifId.valid && !stall &&
                      (ctrl.jump || ctrl.jumpReg || (ctrl.branch && condTrue));

    // base and offset per transfer kind
    always_comb begin
        if (ctrl.jumpReg) begin
            jumpBase = rs1Data;
            jumpOffset = imms.immI;
        end else if (ctrl.jump) begin
            jumpBase = ifId.pc;
            jumpOffset = imms.immJ;
        end else begin
            jumpBase = ifId.pc;
            jumpOffset = imms.immB;
        end
    end

    assign jumpSum = jumpBase + jumpOffset;
    // jalr drops bit 0
    assign target = {jumpSum[XLEN-1:1], jumpSum[0] & ~ctrl.jumpReg};
    assign pcPlus4 = fetchPc + 32'd4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchPc <= '0;
        end else if (redirect) begin
            fetchPc <= target;
        end else if (!stall) begin
            fetchPc <= pcPlus4;
        end
    end

    // wrong-path fetch in IF gets squashed
    assign flush = redirect;

    aPcAligned: assert property (
        @(posedge clk) disable iff (!rstN) fetchPc[1:0] == 2'b00
    ) else $error("fetchPc misaligned %h", fetchPc);

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input logic clk,
    input logic rstN,
    input rvPkg::wbT wb,
    input rvPkg::regAddrT rs1,
    input rvPkg::regAddrT rs2,
    output rvPkg::wordT rs1Data,
    output rvPkg::wordT rs2Data
);
    import rvPkg::*;

    // x0 has no storage
    wordT regs [1:REG_COUNT-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.regWrite && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-through so ID sees the value being retired
    function automatic wordT readPort(regAddrT idx);
        wordT val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.regWrite && wb.rd == idx) begin
            val = wb.data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

    // x0 stays zero even with a write-back aimed at it
    aZeroReg: assert property (
        @(posedge clk) disable iff (!rstN)
        (rs1 != '0 || rs1Data == '0) && (rs2 != '0 || rs2Data == '0)
    ) else $error("x0 read back nonzero");

endmodule

// ==== logic/rvFrontEnd.sv ====
`timescale 1ns/1ps

module rvFrontEnd (
    input logic clk,
    input logic rstN,
    input logic imemWe,
    input rvPkg::imAddrT imemAddr,
    input rvPkg::instrT imemData,
    input logic stall,
    input rvPkg::wbT wb,
    output rvPkg::idExT idEx,
    output rvPkg::wordT fetchPc
);
    import rvPkg::*;

    // IF side
    instrT fetchInstr;
    logic flush;

    // ID side
    ifIdT ifId;
    ctrlT ctrl;
    immSetT imms;
    wordT rs1Data;
    wordT rs2Data;
    logic condTrue;

    insMemory imem0 (
        .clk(clk),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .readAddr(fetchPc),
        .instr(fetchInstr)
    );

    ifIdRegister ifIdReg0 (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .flush(flush),
        .pc(fetchPc),
        .instr(fetchInstr),
        .ifId(ifId)
    );

    controlUnit ctrl0 (
        .instr(ifId.instr),
        .ctrl(ctrl)
    );

    regFile regs0 (
        .clk(clk),
        .rstN(rstN),
        .wb(wb),
        .rs1(ifId.instr[19:15]),
        .rs2(ifId.instr[24:20]),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data)
    );

    // immediates and compare run side by side
    immExtend imm0 (
        .instr(ifId.instr),
        .imms(imms)
    );

    branchCompare cmp0 (
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .funct3(ifId.instr[14:12]),
        .condTrue(condTrue)
    );

    nextPcUnit npc0 (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .ifId(ifId),
        .ctrl(ctrl),
        .imms(imms),
        .rs1Data(rs1Data),
        .condTrue(condTrue),
        .fetchPc(fetchPc),
        .flush(flush)
    );

    idExRegister idExReg0 (
        .clk(clk),
        .rstN(rstN),
        .stall(stall),
        .ifId(ifId),
        .ctrl(ctrl),
        .imms(imms),
        .rs1Data(rs1Data),
        .rs2Data(rs2Data),
        .idEx(idEx)
    );

endmodule

// ==== logic/rvPkg.sv ====
package rvPkg;

    // machine widths
    localparam int XLEN = 32;
    localparam int REG_COUNT = 32;
    localparam int REG_ADDR_W = $clog2(REG_COUNT);

    // instruction RAM geometry in words
    localparam int IM_DEPTH = 256;
    localparam int IM_ADDR_W = $clog2(IM_DEPTH);

    // base opcodes
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;
    localparam logic [6:0] OP_JAL = 7'b1101111;
    localparam logic [6:0] OP_JALR = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_REG = 7'b0110011;

    // branch conditions in funct3
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef logic [XLEN-1:0] wordT;
    typedef logic [31:0] instrT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;
    typedef logic [IM_ADDR_W-1:0] imAddrT;
    typedef logic [2:0] funct3T;
    typedef logic [1:0] aluSrcT;
    typedef logic [1:0] aluOpT;
    typedef logic [2:0] immSelT;

    // addi x0,x0,0
    localparam instrT NOP_INSTR = 32'h0000_0013;

    // immediate kinds, zero means no immediate
    localparam immSelT IMM_NONE = 3'd0;
    localparam immSelT IMM_I = 3'd1;
    localparam immSelT IMM_S = 3'd2;
    localparam immSelT IMM_B = 3'd3;
    localparam immSelT IMM_U = 3'd4;
    localparam immSelT IMM_J = 3'd5;

    // operand A sources
    localparam aluSrcT SRC1_RS1 = 2'd0;
    localparam aluSrcT SRC1_PC = 2'd1;
    localparam aluSrcT SRC1_ZERO = 2'd2;

    // operand B sources
    localparam aluSrcT SRC2_RS2 = 2'd0;
    localparam aluSrcT SRC2_IMM = 2'd1;
    localparam aluSrcT SRC2_FOUR = 2'd2;

    // ALU classes, EX refines with funct3/funct7
    localparam aluOpT ALU_ADD = 2'd0;
    localparam aluOpT ALU_BRANCH = 2'd1;
    localparam aluOpT ALU_REG = 2'd2;
    localparam aluOpT ALU_IMM = 2'd3;

    typedef struct packed {
        logic jump;
        logic jumpReg;
        logic branch;
        logic memRead;
        logic memWrite;
        logic memToReg;
        logic regWrite;
        aluSrcT aluSrc1;
        aluSrcT aluSrc2;
        aluOpT aluOp;
        immSelT immSel;
    } ctrlT;

    typedef struct packed {
        wordT immI;
        wordT immS;
        wordT immB;
        wordT immU;
        wordT immJ;
    } immSetT;

    typedef struct packed {
        logic valid;
        wordT pc;
        instrT instr;
    } ifIdT;

    typedef struct packed {
        logic regWrite;
        regAddrT rd;
        wordT data;
    } wbT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT rs1Data;
        wordT rs2Data;
        wordT imm;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        funct3T funct3;
        logic [6:0] funct7;
        ctrlT ctrl;
    } idExT;

endpackage

// ==== runSim.sh ====
#!/bin/sh
# build and run the front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rvFrontEnd.f --top-module rvFrontEndTb -o simv
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Test completed successfully$"; then
    exit 0
fi
exit 1

// ==== rvFrontEnd.f ====
logic/rvPkg.sv
logic/insMemory.sv
logic/ifIdRegister.sv
logic/controlUnit.sv
logic/regFile.sv
logic/immExtend.sv
logic/branchCompare.sv
logic/nextPcUnit.sv
logic/idExRegister.sv
logic/rvFrontEnd.sv
dv/rvFrontEndTb.sv
